// ==== hw/io_pkg.sv ====
package io_pkg;

  // ************************************************************************
  // bus widths
  // ************************************************************************
  localparam int addr_width = 10;  // data-memory address
  localparam int data_width = 16;  // CPU data word

  // ************************************************************************
  // address map
  // ************************************************************************
  // port word, LCD in the high byte and LED in the low byte
  localparam logic [addr_width-1:0] addr_port    = 10'h080;
  localparam logic [addr_width-1:0] addr_port_hi = 10'h081;  // LCD byte alone
  // command word on write, busy flag in bit 0 on read
  localparam logic [addr_width-1:0] addr_lcd_cmd = 10'h082;

  // ************************************************************************
  // LCD sequencer timing in sys_clk cycles
  // ************************************************************************
  localparam int timer_width = 8;

  localparam logic [timer_width-1:0] lcd_setup_cyc  = 8'd2;   // rs/db ahead of e
  localparam logic [timer_width-1:0] lcd_pulse_cyc  = 8'd12;  // e high
  localparam logic [timer_width-1:0] lcd_hold_cyc   = 8'd12;  // rs/db after e
  localparam logic [timer_width-1:0] lcd_settle_cyc = 8'd50;  // controller exec time

  // two nibbles plus the trailing settle, 102 cycles
  localparam int lcd_busy_cyc =
    2 * (int'(lcd_setup_cyc) + int'(lcd_pulse_cyc) + int'(lcd_hold_cyc)) +
    int'(lcd_settle_cyc);

  // sequencer states
  localparam logic [2:0] st_idle     = 3'd0;
  localparam logic [2:0] st_setup_hi = 3'd1;
  localparam logic [2:0] st_pulse_hi = 3'd2;
  localparam logic [2:0] st_hold_hi  = 3'd3;
  localparam logic [2:0] st_setup_lo = 3'd4;
  localparam logic [2:0] st_pulse_lo = 3'd5;
  localparam logic [2:0] st_hold_lo  = 3'd6;
  localparam logic [2:0] st_settle   = 3'd7;

  // ************************************************************************
  // I/O word, seen whole or as two bytes
  // ************************************************************************
  typedef struct packed {
    logic [7:0] hi;  // LCD port / command high byte
    logic [7:0] lo;  // LED port / command byte
  } io_bytes_t;

  typedef union packed {
    logic [data_width-1:0] raw;
    io_bytes_t             bytes;
  } io_word_u;

endpackage

// ==== hw/lcd_timer.sv ====
module lcd_timer import io_pkg::*; (
  input  logic                   sys_clk,
  input  logic                   rst_n,
  input  logic                   tmr_load,
  input  logic [timer_width-1:0] tmr_count,
  output logic                   tmr_done
);

  logic [timer_width-1:0] cnt_q;    // cycles left minus one
  logic                   running;

  // ************************************************************************
  // down-counter
  // ************************************************************************
  // load in cycle 0 gives done in cycle tmr_count
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      running <= 1'b0;
    end else if (tmr_load) begin
      cnt_q   <= tmr_count - 1'b1;  // restart, even mid-count
      running <= 1'b1;
    end else if (running) begin
      if (cnt_q == '0) begin
        running <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // single-cycle pulse on the last cycle of the phase
  assign tmr_done = running && (cnt_q == '0);

endmodule

// ==== hw/lcd_seq.sv ====
module lcd_seq import io_pkg::*; (
  input  logic                   sys_clk,
  input  logic                   rst_n,
  input  logic                   cmd_start,
  input  logic                   cmd_rs,
  input  logic [7:0]             cmd_byte,
  input  logic [7:0]             lcd_port,
  input  logic                   tmr_done,
  output logic                   tmr_load,
  output logic [timer_width-1:0] tmr_count,
  output logic                   lcd_busy,
  output logic                   lcd_e,
  output logic                   lcd_rw,
  output logic                   lcd_rs,
  output logic                   lcd_bl,
  output logic [3:0]             lcd_db
);

  logic [2:0] state_q;
  logic [2:0] state_d;
  logic       accept;    // command taken this cycle
  logic       rs_q;      // latched register select
  logic [7:0] byte_q;    // latched command byte
  logic       lo_phase;  // low nibble on the bus

  assign accept = (state_q == st_idle) && cmd_start;

  // ************************************************************************
  // next state and timer load
  // ************************************************************************
  always_comb begin
    state_d   = state_q;
    tmr_load  = 1'b0;
    tmr_count = '0;
    case (state_q)
      st_idle: begin
        if (cmd_start) begin
          state_d   = st_setup_hi;
          tmr_load  = 1'b1;
          tmr_count = lcd_setup_cyc;
        end
      end
      st_setup_hi: begin
        if (tmr_done) begin
          state_d   = st_pulse_hi;
          tmr_load  = 1'b1;
          tmr_count = lcd_pulse_cyc;
        end
      end
      st_pulse_hi: begin
        if (tmr_done) begin
          state_d   = st_hold_hi;
          tmr_load  = 1'b1;
          tmr_count = lcd_hold_cyc;
        end
      end
      st_hold_hi: begin
        if (tmr_done) begin
          state_d   = st_setup_lo;  // second nibble
          tmr_load  = 1'b1;
          tmr_count = lcd_setup_cyc;
        end
      end
      st_setup_lo: begin
        if (tmr_done) begin
          state_d   = st_pulse_lo;
          tmr_load  = 1'b1;
          tmr_count = lcd_pulse_cyc;
        end
      end
      st_pulse_lo: begin
        if (tmr_done) begin
          state_d   = st_hold_lo;
          tmr_load  = 1'b1;
          tmr_count = lcd_hold_cyc;
        end
      end
      st_hold_lo: begin
        if (tmr_done) begin
          state_d   = st_settle;
          tmr_load  = 1'b1;
          tmr_count = lcd_settle_cyc;
        end
      end
      st_settle: begin
        if (tmr_done) begin
          state_d = st_idle;  // no reload, back to idle
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // command copy, held for the whole transfer
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      rs_q   <= cmd_rs;
      byte_q <= cmd_byte;
    end
  end

  // ************************************************************************
  // pin steering
  // ************************************************************************
  assign lcd_busy = (state_q != st_idle);
  assign lo_phase = (state_q == st_setup_lo) || (state_q == st_pulse_lo) ||
                    (state_q == st_hold_lo)  || (state_q == st_settle);

  always_comb begin
    if (!lcd_busy) begin
      lcd_e  = lcd_port[0];  // software drives the pins directly
      lcd_rw = lcd_port[1];
      lcd_rs = lcd_port[2];
      lcd_db = lcd_port[7:4];
    end else begin
      lcd_e  = (state_q == st_pulse_hi) || (state_q == st_pulse_lo);
      lcd_rw = 1'b0;  // write only
      lcd_rs = rs_q;
      lcd_db = lo_phase ? byte_q[3:0] : byte_q[7:4];
    end
  end

  assign lcd_bl = lcd_port[3];  // never overridden

endmodule

// ==== hw/io_regs.sv ====
module io_regs import io_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  input  logic [addr_width-1:0] dmem_addr,
  input  logic                  dmem_wen,
  input  logic                  dmem_byt,
  input  logic [data_width-1:0] dmem_wdata,
  output logic [data_width-1:0] dmem_rdata,
  input  logic                  lcd_busy,
  output logic [5:0]            led,
  output logic [7:0]            lcd_port,
  output logic                  cmd_start,
  output logic                  cmd_rs,
  output logic [7:0]            cmd_byte
);

  io_word_u              wr_word;    // write data, byte view for the split
  io_word_u              port_q;     // hi = LCD register, lo = LED register
  logic [addr_width-1:0] addr_d;     // address of the previous cycle
  logic                  hit_port;
  logic                  hit_port_hi;
  logic                  hit_cmd;

  assign wr_word.raw = dmem_wdata;

  // ************************************************************************
  // address decode
  // ************************************************************************
  assign hit_port    = dmem_wen && (dmem_addr == addr_port);
  assign hit_port_hi = dmem_wen && (dmem_addr == addr_port_hi);
  assign hit_cmd     = dmem_wen && (dmem_addr == addr_lcd_cmd);

  // ************************************************************************
  // LED / LCD port registers
  // ************************************************************************
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      port_q.raw <= '0;
    end else if (hit_port) begin
      if (dmem_byt) begin
        port_q.bytes.lo <= wr_word.bytes.lo;  // LED only
      end else begin
        port_q.raw <= wr_word.raw;            // LCD and LED together
      end
    end else if (hit_port_hi) begin
      // byte lane of 0x081 is the upper half
      port_q.bytes.hi <= wr_word.bytes.hi;
    end
  end

  // board LEDs light on a low level
  assign led      = ~port_q.bytes.lo[5:0];
  assign lcd_port = port_q.bytes.hi;

  // ************************************************************************
  // command launch
  // ************************************************************************
  // one strobe per write, the sequencer drops it when busy
  assign cmd_start = hit_cmd;
  assign cmd_rs    = wr_word.bytes.hi[0];  // bit 8
  assign cmd_byte  = wr_word.bytes.lo;

  // ************************************************************************
  // read path
  // ************************************************************************
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_d <= '0;
    end else begin
      addr_d <= dmem_addr;
    end
  end

  // answers the address of the previous cycle
  always_comb begin
    case (addr_d)
      addr_port,
      addr_port_hi: begin
        dmem_rdata = port_q.raw;
      end
      addr_lcd_cmd: begin
        dmem_rdata = {{(data_width-1){1'b0}}, lcd_busy};  // status word
      end
      default: begin
        dmem_rdata = '0;  // unmapped here
      end
    endcase
  end

endmodule

// ==== hw/io_top.sv ====
module io_top import io_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  rst_n,
  // CPU data-memory port
  input  logic [addr_width-1:0] dmem_addr,
  input  logic                  dmem_wen,
  input  logic                  dmem_byt,
  input  logic [data_width-1:0] dmem_wdata,
  output logic [data_width-1:0] dmem_rdata,
  // board pins
  output logic [5:0]            led,     // active low
  output logic                  lcd_e,
  output logic                  lcd_rw,
  output logic                  lcd_rs,
  output logic                  lcd_bl,
  output logic [3:0]            lcd_db   // 4-bit bus mode
);

  logic [7:0]             lcd_port;
  logic                   cmd_start;
  logic                   cmd_rs;
  logic [7:0]             cmd_byte;
  logic                   lcd_busy;
  logic                   tmr_load;
  logic [timer_width-1:0] tmr_count;
  logic                   tmr_done;

  // ************************************************************************
  // register block on the CPU bus
  // ************************************************************************
  io_regs u_io_regs (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .dmem_addr  (dmem_addr),
    .dmem_wen   (dmem_wen),
    .dmem_byt   (dmem_byt),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .lcd_busy   (lcd_busy),
    .led        (led),
    .lcd_port   (lcd_port),
    .cmd_start  (cmd_start),
    .cmd_rs     (cmd_rs),
    .cmd_byte   (cmd_byte)
  );

  // ************************************************************************
  // LCD command path
  // ************************************************************************
  lcd_seq u_lcd_seq (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .cmd_start (cmd_start),
    .cmd_rs    (cmd_rs),
    .cmd_byte  (cmd_byte),
    .lcd_port  (lcd_port),
    .tmr_done  (tmr_done),
    .tmr_load  (tmr_load),
    .tmr_count (tmr_count),
    .lcd_busy  (lcd_busy),
    .lcd_e     (lcd_e),
    .lcd_rw    (lcd_rw),
    .lcd_rs    (lcd_rs),
    .lcd_bl    (lcd_bl),
    .lcd_db    (lcd_db)
  );

  lcd_timer u_lcd_timer (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .tmr_load  (tmr_load),
    .tmr_count (tmr_count),
    .tmr_done  (tmr_done)   // phase end
  );

endmodule

// ==== tests/tb_io_lib.svh ====
`ifndef tb_io_lib_svh
`define tb_io_lib_svh

  // ************************************************************************
  // CPU bus
  // ************************************************************************
  task automatic bus_write(input logic [addr_width-1:0] addr, input logic byt,
                           input logic [data_width-1:0] data);
    @(posedge sys_clk);
    #5;
    dmem_addr  = addr;
    dmem_wen   = 1'b1;
    dmem_byt   = byt;
    dmem_wdata = data;
    @(posedge sys_clk);
    #5;
    dmem_wen   = 1'b0;
    dmem_byt   = 1'b0;
    port_model = apply_write(port_model, addr, byt, data);  // taken on that edge
  endtask

  // data belongs to the address of the cycle before
  task automatic bus_read(input logic [addr_width-1:0] addr, output logic [31:0] data);
    @(posedge sys_clk);
    #5;
    dmem_addr = addr;
    @(posedge sys_clk);
    #5;
    dmem_addr = '0;  // live address must not matter now
    #1;
    data = dmem_rdata;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  // ************************************************************************
  // random bits, Galois LFSR x^32+x^22+x^2+x+1
  // ************************************************************************
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // ************************************************************************
  // reference models
  // ************************************************************************
  function automatic io_word_u apply_write(input io_word_u port,
                                           input logic [addr_width-1:0] addr,
                                           input logic byt,
                                           input logic [data_width-1:0] data);
    io_word_u w;
    io_word_u r;
    w.raw = data;
    r     = port;
    if (addr == addr_port && byt) begin
      r.bytes.lo = w.bytes.lo;  // LED byte only
    end else if (addr == addr_port) begin
      r.raw = w.raw;
    end else if (addr == addr_port_hi) begin
      r.bytes.hi = w.bytes.hi;  // LCD byte on the upper lane
    end
    return r;
  endfunction

  function automatic logic [31:0] ref_read(input logic [addr_width-1:0] addr,
                                           input io_word_u port, input logic busy);
    if (addr == addr_port || addr == addr_port_hi) begin
      return {16'h0, port.raw};
    end else if (addr == addr_lcd_cmd) begin
      return {31'd0, busy};
    end
    return '0;
  endfunction

  // high nibble goes out first, each tagged with rs
  function automatic logic [9:0] ref_nibbles(input logic rs, input logic [7:0] cmd);
    return {rs, cmd[7:4], rs, cmd[3:0]};
  endfunction

  // pins when the sequencer is idle
  task automatic check_pins();
    logic [5:0] led_exp;
    led_exp = ~port_model.bytes.lo[5:0];  // board LEDs are active low
    check_value("led", led_exp, led);
    check_value("lcd_e", port_model.bytes.hi[0], lcd_e);
    check_value("lcd_rw", port_model.bytes.hi[1], lcd_rw);
    check_value("lcd_rs", port_model.bytes.hi[2], lcd_rs);
    check_value("lcd_bl", port_model.bytes.hi[3], lcd_bl);
    check_value("lcd_db", port_model.bytes.hi[7:4], lcd_db);
  endtask

`endif

// ==== tests/tb_io_top.sv ====
module tb_io_top import io_pkg::*; ();

  logic                  sys_clk;
  logic                  rst_n;
  logic [addr_width-1:0] dmem_addr;
  logic                  dmem_wen;
  logic                  dmem_byt;
  logic [data_width-1:0] dmem_wdata;
  logic [data_width-1:0] dmem_rdata;
  logic [5:0]            led;
  logic                  lcd_e;
  logic                  lcd_rw;
  logic                  lcd_rs;
  logic                  lcd_bl;
  logic [3:0]            lcd_db;

  int          checks;
  int          errors;
  int          e_falls;     // falling edges of e seen while armed
  logic        mon_armed;
  logic [4:0]  exp_nib[$];  // {rs, nibble} in send order
  io_word_u    port_model;  // hi = LCD register, lo = LED register
  logic [31:0] lfsr_q;

  `include "tb_io_lib.svh"

  io_top uut (.*);

  always #20 sys_clk = ~sys_clk;

  // ************************************************************************
  // nibble monitor, the LCD latches on the falling edge of e
  // ************************************************************************
  always @(negedge lcd_e) begin
    if (mon_armed) begin
      #1;
      e_falls++;
      if (exp_nib.size() == 0) begin
        errors++;
        $display("unexpected e pulse at %0t", $time);
      end else begin
        check_value("lcd_rs/lcd_db", exp_nib.pop_front(), {lcd_rs, lcd_db});
      end
    end
  end

  task automatic report_test(input string name, input int mark);
    $display("test %-16s %0d errors", name, errors - mark);
  endtask

  // one command, busy counted through status reads of 0x082
  task automatic run_command(input logic rs, input logic [7:0] cmd, input logic overlap);
    logic [9:0]  nibs;
    logic [31:0] r;
    int          busy_cnt;
    nibs = ref_nibbles(rs, cmd);
    exp_nib.push_back(nibs[9:5]);
    exp_nib.push_back(nibs[4:0]);
    e_falls   = 0;
    mon_armed = 1'b1;
    bus_write(addr_lcd_cmd, 1'b0, {7'd0, rs, cmd});
    busy_cnt = 0;
    while (dmem_rdata[0] === 1'b1 && busy_cnt < 4 * lcd_busy_cyc) begin
      busy_cnt++;
      check_value("lcd_rw", 0, lcd_rw);
      check_value("lcd_bl", port_model.bytes.hi[3], lcd_bl);
      if (overlap && busy_cnt == 30) begin
        rand_bits(9, r);
        dmem_wdata = {7'd0, r[8:0]};
        dmem_wen   = 1'b1;  // lands while busy
      end else begin
        dmem_wen = 1'b0;
      end
      @(posedge sys_clk);
      #5;
    end
    dmem_wen = 1'b0;
    if (busy_cnt >= 4 * lcd_busy_cyc) begin
      errors++;
      $display("timeout: lcd busy still high after %0d cycles", busy_cnt);
    end
    check_value("busy cycles", lcd_busy_cyc, busy_cnt);
    mon_armed = 1'b0;
    check_value("e falls", 2, e_falls);
    check_value("nibbles left", 0, exp_nib.size());
    exp_nib.delete();
    check_pins();  // back to the raw port register
  endtask

  initial begin : test_seq
    int                    mark;
    logic [31:0]           r;
    logic [addr_width-1:0] a;
    logic                  byt;
    sys_clk        = 1'b0;
    rst_n          = 1'b0;
    dmem_addr      = '0;
    dmem_wen       = 1'b0;
    dmem_byt       = 1'b0;
    dmem_wdata     = '0;
    checks         = 0;
    errors         = 0;
    e_falls        = 0;
    mon_armed      = 1'b0;
    port_model.raw = '0;
    lfsr_q         = 32'h9c50_a020;
    repeat (16) @(posedge sys_clk);
    #5;
    rst_n = 1'b1;

    mark = errors;
    check_pins();
    bus_read(addr_port, r);
    check_value("dmem_rdata", 0, r);
    report_test("reset values", mark);

    mark = errors;
    for (int i = 0; i < 40; i++) begin
      rand_bits(1, r);
      a = r[0] ? addr_port_hi : addr_port;
      rand_bits(1, r);
      byt = r[0];
      rand_bits(16, r);
      bus_write(a, byt, r[15:0]);
      check_pins();
    end
    report_test("port writes", mark);

    mark = errors;
    for (int i = 0; i < 11; i++) begin
      if (i < 3) begin
        a = (i == 0) ? addr_port : (i == 1) ? addr_port_hi : addr_lcd_cmd;
      end else begin
        rand_bits(10, r);
        a = r[9:0];
      end
      bus_read(a, r);
      check_value("dmem_rdata", ref_read(a, port_model, 1'b0), r);
    end
    report_test("reads", mark);

    mark = errors;
    rand_bits(8, r);
    bus_write(addr_port_hi, 1'b0, {(r[7:0] & 8'hfe) | 8'h02, 8'h00});  // e low, rw high
    for (int i = 0; i < 3; i++) begin
      rand_bits(9, r);
      run_command(r[8], r[7:0], 1'b0);
    end
    report_test("lcd command", mark);

    mark = errors;
    rand_bits(9, r);
    run_command(r[8], r[7:0], 1'b1);
    report_test("busy and overlap", mark);

    mark = errors;
    bus_write(addr_port_hi, 1'b0, {port_model.bytes.hi ^ 8'h08, 8'h00});  // flip backlight
    rand_bits(9, r);
    run_command(r[8], r[7:0], 1'b0);
    report_test("pin return", mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+tests
hw/io_pkg.sv
hw/lcd_timer.sv
hw/lcd_seq.sv
hw/io_regs.sv
hw/io_top.sv
tests/tb_io_top.sv
